// ==== eyeriss_array.f ====
+incdir+verilog
verilog/eyeriss_pkg.sv
verilog/pe_mac.sv
verilog/pe_border.sv
verilog/pe_inner.sv
verilog/array_eyeriss.sv
testbench/tb_array_eyeriss.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f eyeriss_array.f \
    --top-module tb_array_eyeriss \
    -Mdir obj_dir \
    -o sim_tb_array_eyeriss

# A failing check ends in $fatal, which gives a non-zero exit status.
./obj_dir/sim_tb_array_eyeriss

// ==== testbench/array_eyeriss_testdata.txt ====
# W col w0 w1 w2 | I row v0 v1 v2 | S row n v0 v1 v2 | D row | R row | K col
# Q col clr expected_sum | A expected sums of columns 0 to 3
W 0 1 2 3
W 1 -1 0 2
W 2 4 -3 1
W 3 2 2 -1
I 0 1 2 3
I 1 -2 5 1
I 2 3 -1 4
Q 0 0 38
Q 1 0 14
Q 2 0 -2
Q 3 0 8
A 38 14 -2 8
# Row clr part way through a window on row 1.
S 1 2 7 7 0
R 1
I 1 2 -1 3
A 36 14 34 2
# Second window on row 2 waits behind the held one.
I 2 1 1 1
S 2 3 5 0 -2
A 29 10 17 5
D 2
A 22 0 33 14
# Psum clr empties column 2 once.
Q 2 1 33
Q 2 0 0
Q 3 0 14
# Column clr on column 0, then fresh windows in every row.
K 0
I 0 2 0 -1
I 1 0 3 1
I 2 -1 2 2
A 0 3 -9 10
W 0 -2 1 3
I 0 1 1 1
Q 0 1 2
Q 0 0 0

// ==== testbench/tb_array_eyeriss.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "eyeriss_macros.svh"

module tb_array_eyeriss import eyeriss_pkg::*; ();

    logic      clk = 1'b0;
    logic      arst_n_i;
    row_bus_t  row_in  [`EYE_HEIGHT-1:0];
    col_bus_t  col_in  [`EYE_WIDTH-1:0];
    psum_bus_t psum_in [`EYE_WIDTH-1:0];
    psum_bus_t ofm_out [`EYE_WIDTH-1:0];

    string     cmd_lines [$];
    int        n_cmds = 0;

    array_eyeriss dut_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .row_i    (row_in),
        .col_i    (col_in),
        .psum_i   (psum_in),
        .ofm_o    (ofm_out)
    );

    always #4 clk = ~clk;                     // 8 ns period.

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "Value mismatch on %s.", name);
        end
    endtask

    task automatic clear_inputs();
        for (int h = 0; h < `EYE_HEIGHT; h++) begin
            row_in[h] = '0;
        end
        for (int w = 0; w < `EYE_WIDTH; w++) begin
            col_in[w]  = '0;
            psum_in[w] = '0;
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            clear_inputs();
        end
    endtask

    // One request per cycle on count columns from first. Each answer must leave
    // the top row exactly EYE_HEIGHT cycles after its request, and no other.
    task automatic run_psum(input int first, input int count, input logic clr_req,
                            input int exp_sum [`EYE_WIDTH]);
        int   due;
        logic exp_en;
        for (int t = 0; t < count + `EYE_HEIGHT; t++) begin
            @(negedge clk);
            due = t - `EYE_HEIGHT;
            for (int w = 0; w < `EYE_WIDTH; w++) begin
                exp_en = (due >= 0) && (w == first + due);
                check_value($sformatf("ofm_o[%0d].en", w), int'(ofm_out[w].en), int'(exp_en));
                check_value($sformatf("ofm_o[%0d].clr", w), int'(ofm_out[w].clr),
                            int'(exp_en && clr_req));
                if (exp_en) begin
                    check_value($sformatf("ofm_o[%0d].ofm", w),
                                int'($signed(ofm_out[w].ofm)), exp_sum[due]);
                end
            end
            clear_inputs();
            if (t < count) begin
                psum_in[first + t].en  = 1'b1;
                psum_in[first + t].clr = clr_req;
            end
        end
    endtask

    initial begin : main
        int         fd;
        int         rc;
        int         n;
        int         base;
        string      line;
        logic [7:0] cmd;
        int         a0, a1, a2, a3, a4;
        int         f [5];
        int         exp_sum [`EYE_WIDTH];

        arst_n_i = 1'b0;
        clear_inputs();

        fd = $fopen("testbench/array_eyeriss_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/array_eyeriss_testdata.txt.");
            $display("*** TEST FAILED ***");
            $fatal(1, "Missing test data.");
        end
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc > 1 && line[0] != "#") begin
                cmd_lines.push_back(line);
            end
        end
        $fclose(fd);
        if (cmd_lines.size() == 0) begin
            $display("The test data file holds no commands.");
            $display("*** TEST FAILED ***");
            $fatal(1, "Empty test data.");
        end
        n_cmds = cmd_lines.size();

        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        @(negedge clk);
        for (int w = 0; w < `EYE_WIDTH; w++) begin
            check_value($sformatf("ofm_o[%0d].en", w), int'(ofm_out[w].en), 0);
            check_value($sformatf("ofm_o[%0d].ofm", w), int'($signed(ofm_out[w].ofm)), 0);
        end

        for (int i = 0; i < n_cmds; i++) begin
            rc = $sscanf(cmd_lines[i], "%c %d %d %d %d %d", cmd, a0, a1, a2, a3, a4);
            f  = '{a0, a1, a2, a3, a4};
            case (cmd)
                "W": begin
                    for (int k = 0; k < `EYE_IDEPTH; k++) begin
                        @(negedge clk);
                        clear_inputs();
                        col_in[f[0]].en   = 1'b1;
                        col_in[f[0]].wght = `EYE_IWIDTH'(f[1+k]);
                    end
                end
                "I", "S": begin
                    n    = (cmd == "I") ? `EYE_IDEPTH : f[1];
                    base = (cmd == "I") ? 1 : 2;
                    for (int k = 0; k < n; k++) begin
                        @(negedge clk);
                        clear_inputs();
                        row_in[f[0]].en       = 1'b1;
                        row_in[f[0]].ifm      = `EYE_IWIDTH'(f[base+k]);
                        row_in[f[0]].mac_done = (cmd == "I") && (k == n - 1);
                    end
                end
                "D", "R", "K": begin
                    @(negedge clk);
                    clear_inputs();
                    if (cmd == "D") begin
                        row_in[f[0]].mac_done = 1'b1;
                    end else if (cmd == "R") begin
                        row_in[f[0]].clr = 1'b1;
                    end else begin
                        col_in[f[0]].clr = 1'b1;
                    end
                end
                "Q": begin
                    exp_sum[0] = f[2];
                    run_psum(f[0], 1, f[1] != 0, exp_sum);
                end
                "A": begin
                    for (int w = 0; w < `EYE_WIDTH; w++) begin
                        exp_sum[w] = f[w];
                    end
                    run_psum(0, `EYE_WIDTH, 1'b0, exp_sum);
                end
                default: begin
                    $display("Unknown command in test data line %0d: %s", i, cmd_lines[i]);
                    $display("*** TEST FAILED ***");
                    $fatal(1, "Bad test data.");
                end
            endcase
            idle(`EYE_WIDTH + `EYE_HEIGHT);   // Let strobes cross the array.
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin : watchdog
        wait (n_cmds > 0);
        repeat (n_cmds * 40 + 20) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles.", n_cmds * 40 + 20);
        $display("*** TEST FAILED ***");
        $fatal(1, "Watchdog expired.");
    end

endmodule

`default_nettype wire

// ==== verilog/array_eyeriss.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "eyeriss_macros.svh"

module array_eyeriss import eyeriss_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  row_bus_t  row_i  [`EYE_HEIGHT-1:0],
    input  col_bus_t  col_i  [`EYE_WIDTH-1:0],
    input  psum_bus_t psum_i [`EYE_WIDTH-1:0],
    output psum_bus_t ofm_o  [`EYE_WIDTH-1:0]
);

    // Row buses run rightward. Entry w feeds the PE in column w.
    row_bus_t  row_x  [`EYE_HEIGHT-1:0][`EYE_WIDTH:0];
    // Column buses run downward. Entry h feeds the PE in row h.
    col_bus_t  col_x  [`EYE_WIDTH-1:0][`EYE_HEIGHT:0];
    // Psum buses run upward. Entry h+1 feeds row h.
    psum_bus_t psum_x [`EYE_WIDTH-1:0][`EYE_HEIGHT:0];

    for (genvar h = 0; h < `EYE_HEIGHT; h++) begin : g_row_edge
        assign row_x[h][0] = row_i[h];
    end

    for (genvar w = 0; w < `EYE_WIDTH; w++) begin : g_col_edge
        assign col_x[w][0] = col_i[w];

        // Zero sum enters below the bottom row.
        assign psum_x[w][`EYE_HEIGHT] = '{
            en:  psum_i[w].en,
            clr: psum_i[w].clr,
            ofm: '0
        };

        assign ofm_o[w] = psum_x[w][0];
    end

    for (genvar h = 0; h < `EYE_HEIGHT; h++) begin : g_row
        pe_border u_pe_border (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .row_i    (row_x[h][0]),
            .col_i    (col_x[0][h]),
            .psum_i   (psum_x[0][h+1]),
            .row_o    (row_x[h][1]),
            .col_o    (col_x[0][h+1]),
            .psum_o   (psum_x[0][h])
        );

        for (genvar w = 1; w < `EYE_WIDTH; w++) begin : g_col
            pe_inner u_pe_inner (
                .clk      (clk),
                .arst_n_i (arst_n_i),
                .row_i    (row_x[h][w]),
                .col_i    (col_x[w][h]),
                .psum_i   (psum_x[w][h+1]),
                .row_o    (row_x[h][w+1]),
                .col_o    (col_x[w][h+1]),
                .psum_o   (psum_x[w][h])
            );
        end
    end

endmodule

`default_nettype wire

// ==== verilog/eyeriss_macros.svh ====
`ifndef EYERISS_MACROS_SVH
`define EYERISS_MACROS_SVH

// Array size.
`define EYE_HEIGHT 3
`define EYE_WIDTH  4

// Signed ifm and weight width.
`define EYE_IWIDTH 8

// Filter taps per row and scratchpad depth.
`define EYE_IDEPTH 3

// Tap index width.
`define EYE_IDXW ($clog2(`EYE_IDEPTH))

// Signed accumulator and partial sum width.
`define EYE_OWIDTH 24

`endif

// ==== verilog/eyeriss_pkg.sv ====
`default_nettype none

`include "eyeriss_macros.svh"

package eyeriss_pkg;

    // Travels right along a row by one PE per cycle.
    typedef struct packed {
        logic                          en;       // Valid ifm.
        logic                          clr;      // Clears accumulator and tap index.
        logic                          mac_done; // Accumulator to hold register.
        logic [`EYE_IDXW-1:0]          idx;      // Tap index from the border PE.
        logic signed [`EYE_IWIDTH-1:0] ifm;
    } row_bus_t;

    // Travels down a column by one PE per cycle.
    typedef struct packed {
        logic                          en;   // Shifts wght into the scratchpad.
        logic                          clr;  // Zeroes the scratchpad.
        logic signed [`EYE_IWIDTH-1:0] wght;
    } col_bus_t;

    // Travels up a column by one PE per cycle.
    typedef struct packed {
        logic                          en;   // Valid partial sum.
        logic                          clr;  // Clears hold registers on the way.
        logic signed [`EYE_OWIDTH-1:0] ofm;
    } psum_bus_t;

endpackage

`default_nettype wire

// ==== verilog/pe_border.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "eyeriss_macros.svh"

module pe_border import eyeriss_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  row_bus_t  row_i,
    input  col_bus_t  col_i,
    input  psum_bus_t psum_i,
    output row_bus_t  row_o,
    output col_bus_t  col_o,
    output psum_bus_t psum_o
);

    logic [`EYE_IDXW-1:0] idx_q;
    row_bus_t             row_idx;

    // Tap counter for the whole row.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            idx_q <= '0;
        end else if (row_i.clr) begin
            idx_q <= '0;
        end else if (row_i.en) begin
            idx_q <= (idx_q == `EYE_IDEPTH - 1) ? '0 : idx_q + 1'b1;
        end
    end

    always_comb begin
        row_idx     = row_i;
        row_idx.idx = idx_q;                  // Incoming idx is ignored.
    end

    pe_mac u_pe_mac (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .row_i    (row_idx),
        .col_i    (col_i),
        .psum_i   (psum_i),
        .row_o    (row_o),
        .col_o    (col_o),
        .psum_o   (psum_o)
    );

    a_idx_max: assert property (@(posedge clk) disable iff (!arst_n_i)
        idx_q <= `EYE_IDEPTH - 1);

endmodule

`default_nettype wire

// ==== verilog/pe_inner.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "eyeriss_macros.svh"

module pe_inner import eyeriss_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  row_bus_t  row_i,
    input  col_bus_t  col_i,
    input  psum_bus_t psum_i,
    output row_bus_t  row_o,
    output col_bus_t  col_o,
    output psum_bus_t psum_o
);

    // Tap index arrives with the data from the left neighbour.
    pe_mac u_pe_mac (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .row_i    (row_i),
        .col_i    (col_i),
        .psum_i   (psum_i),
        .row_o    (row_o),
        .col_o    (col_o),
        .psum_o   (psum_o)
    );

endmodule

`default_nettype wire

// ==== verilog/pe_mac.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "eyeriss_macros.svh"

module pe_mac import eyeriss_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  row_bus_t  row_i,
    input  col_bus_t  col_i,
    input  psum_bus_t psum_i,
    output row_bus_t  row_o,
    output col_bus_t  col_o,
    output psum_bus_t psum_o
);

    logic signed [`EYE_IWIDTH-1:0]   spad_q [`EYE_IDEPTH];
    logic signed [`EYE_OWIDTH-1:0]   acc_q;
    logic signed [`EYE_OWIDTH-1:0]   hold_q;
    logic signed [2*`EYE_IWIDTH-1:0] prod;
    logic signed [`EYE_OWIDTH-1:0]   acc_sum;

    assign prod = row_i.ifm * spad_q[row_i.idx];

    // Accumulator including this cycle's product.
    always_comb begin
        acc_sum = acc_q;
        if (row_i.en) begin
            acc_sum = acc_q + prod;
        end
    end

    // Weight scratchpad. The first weight sent ends up in entry 0.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int k = 0; k < `EYE_IDEPTH; k++) begin
                spad_q[k] <= '0;
            end
        end else if (col_i.clr) begin
            for (int k = 0; k < `EYE_IDEPTH; k++) begin
                spad_q[k] <= '0;
            end
        end else if (col_i.en) begin
            for (int k = 0; k < `EYE_IDEPTH - 1; k++) begin
                spad_q[k] <= spad_q[k+1];
            end
            spad_q[`EYE_IDEPTH-1] <= col_i.wght;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            acc_q <= '0;
        end else if (row_i.clr || row_i.mac_done) begin
            acc_q <= '0;                      // Next window starts from zero.
        end else if (row_i.en) begin
            acc_q <= acc_sum;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hold_q <= '0;
        end else if (row_i.mac_done) begin
            hold_q <= acc_sum;
        end else if (psum_i.clr) begin
            hold_q <= '0;                     // Old value already went into the sum.
        end
    end

    // Forwarding registers towards the neighbours.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            row_o  <= '0;
            col_o  <= '0;
            psum_o <= '0;
        end else begin
            row_o      <= row_i;
            col_o      <= col_i;
            psum_o.en  <= psum_i.en;
            psum_o.clr <= psum_i.clr;
            if (psum_i.en) begin
                psum_o.ofm <= psum_i.ofm + hold_q;
            end else begin
                psum_o.ofm <= '0;
            end
        end
    end

    a_row_en_clr: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(row_i.en && row_i.clr));

    a_col_en_clr: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(col_i.en && col_i.clr));

    a_idx_range: assert property (@(posedge clk) disable iff (!arst_n_i)
        row_i.en |-> (row_i.idx < `EYE_IDEPTH));

endmodule

`default_nettype wire
